// ==== verilog/ctl65_settings.svh ====
// Shared constants for the ctl65 sequencer.
// Include this file in any unit that needs the bus width, the opcode values
// or the register and source codes.
`ifndef CTL65_SETTINGS_SVH
`define CTL65_SETTINGS_SVH

`define CTL65_DATA_W    8           // Data bus width

// Decoded opcodes
`define OP_LDA_IMM      8'hA9       // LDA #IMM
`define OP_LDA_ZP       8'hA5       // LDA ZP
`define OP_LDA_ZPX      8'hB5       // LDA ZP,X
`define OP_LDA_ABS      8'hAD       // LDA ABS
`define OP_LDA_ABSX     8'hBD       // LDA ABS,X
`define OP_LDA_ABSY     8'hB9       // LDA ABS,Y
`define OP_LDA_INDX     8'hA1       // LDA (ZP,X)
`define OP_LDA_INDZ     8'hB2       // LDA (ZP)
`define OP_LDA_INDY     8'hB1       // LDA (ZP),Y
`define OP_LDX_IMM      8'hA2       // LDX #IMM
`define OP_LDX_ZPY      8'hB6       // LDX ZP,Y
`define OP_LDY_IMM      8'hA0       // LDY #IMM
`define OP_INX          8'hE8       // INX
`define OP_DEX          8'hCA       // DEX
`define OP_BRA          8'h80       // BRA rel
`define OP_JMP_ABS      8'h4C       // JMP ABS
`define OP_JMP_IND      8'h6C       // JMP (IND)
`define OP_JMP_INDX     8'h7C       // JMP (IND,X)

// Register file destinations
`define REG_X           2'd0
`define REG_Y           2'd1
`define REG_A           2'd2
`define REG_S           2'd3

// Register file sources, Z and M land on the same read port
`define SRC_X           4'd0
`define SRC_Y           4'd1
`define SRC_Z           4'd7        // Zero offset
`define SRC_M           4'd7        // Memory operand

`endif

// ==== verilog/ctl65_pkg.sv ====
// Types shared by the ctl65 units: sequencer states, the held instruction
// fields and the three control words handed to the datapath.
`default_nettype none

package ctl65_pkg;

    // Sequencer states, codes kept from the full core
    typedef enum logic [5:0] {
        INIT = 6'd0,
        SYNC = 6'd1,                        // Opcode fetch
        BACK = 6'd2,                        // Operand read, back to PC
        IMM0 = 6'd3,
        IND0 = 6'd4,
        IND1 = 6'd5,
        ABS0 = 6'd7,
        ABS1 = 6'd8,
        ZERO = 6'd9,
        IND2 = 6'd10,
        COND = 6'd28                        // Branch offset
    } state_t;

    // Fields latched at fetch
    typedef struct packed {
        logic       ld;                     // Write register at next fetch
        logic [1:0] dst;
        logic [3:0] src;
        logic [6:0] alu;                    // shift, add, carry
        logic       add_x;                  // Index with X
        logic       add_y;                  // Index with Y
        logic       jmp;                    // Address is a jump target
        logic       ind;                    // One more indirection
    } instr_t;

    // Address path modes in use
    typedef enum logic [3:0] {
        AB_KEEP   = 4'd0,                   // AB unchanged
        AB_PC     = 4'd1,                   // AB from PC
        AB_ABS_PC = 4'd2,                   // {DB, AHL+XYZ}, PC <= AB+1
        AB_ZP_PC  = 4'd3,                   // {00, DB+XYZ}, PC <= AB+1
        AB_INC_PC = 4'd4,                   // AB+1, PC <= AB
        AB_BRANCH = 4'd7,                   // AB + offset + 1
        AB_ABS    = 4'd10,                  // {DB, AHL+XYZ}, keep PC
        AB_INC    = 4'd12                   // AB+1, keep PC
    } ab_mode_t;

    typedef struct packed {
        logic [6:0] iph_abh;
        logic [1:0] abl_sel;
        logic [1:0] abl_src;
        logic       abl_ci;
    } ab_op_t;

    typedef struct packed {
        logic       write;
        logic [1:0] dst;
        logic [3:0] src;
    } reg_op_t;

    typedef struct packed {
        logic       ldm;                    // Load memory operand
        logic       bcd;
        logic [1:0] shift;
        logic [2:0] add;
        logic [1:0] carry;
    } alu_op_t;

endpackage

`default_nettype wire

// ==== verilog/opcode_decode.sv ====
// Opcode decode. Matches the data bus byte during fetch, gives the sequencer
// its entry state and latches the instruction fields for the following states.
`timescale 1ns/1ns
`default_nettype none
`include "ctl65_settings.svh"

module opcode_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rdy,
    input  logic                     sync,
    input  ctl65_pkg::state_t        state,
    input  logic [`CTL65_DATA_W-1:0] db,
    output ctl65_pkg::instr_t        instr,
    output ctl65_pkg::state_t        entry
);

    localparam logic [6:0] ALU_PASS = 7'b00_011_00;    // ADD with no carry, passes M
    localparam logic [6:0] ALU_INC  = 7'b00_100_01;    // + 1
    localparam logic [6:0] ALU_DEC  = 7'b00_101_00;    // - 1
    localparam logic [6:0] ALU_NONE = 7'b11_111_11;    // Unused code

    ctl65_pkg::instr_t dec;                            // Fields for the byte on db

    // First state after SYNC
    always_comb begin
        case (db)
            `OP_LDA_IMM, `OP_LDX_IMM, `OP_LDY_IMM:
                entry = ctl65_pkg::IMM0;
            `OP_LDA_ZP, `OP_LDA_ZPX, `OP_LDX_ZPY:
                entry = ctl65_pkg::ZERO;
            `OP_LDA_ABS, `OP_LDA_ABSX, `OP_LDA_ABSY,
            `OP_JMP_ABS, `OP_JMP_IND, `OP_JMP_INDX:
                entry = ctl65_pkg::ABS0;
            `OP_LDA_INDX, `OP_LDA_INDZ, `OP_LDA_INDY:
                entry = ctl65_pkg::IND0;
            `OP_BRA:
                entry = ctl65_pkg::COND;
            default:
                entry = ctl65_pkg::SYNC;               // Acts as a one-cycle NOP
        endcase
    end

    always_comb begin
        dec     = '0;                                  // No write-back by default
        dec.dst = `REG_X;
        dec.src = `SRC_Z;
        dec.alu = ALU_NONE;
        case (db)
            `OP_LDA_IMM, `OP_LDA_ZP, `OP_LDA_ZPX, `OP_LDA_ABS, `OP_LDA_ABSX,
            `OP_LDA_ABSY, `OP_LDA_INDX, `OP_LDA_INDZ, `OP_LDA_INDY: begin
                dec.ld  = 1'b1;                        // A <= M
                dec.dst = `REG_A;
                dec.src = `SRC_M;
                dec.alu = ALU_PASS;
            end
            `OP_LDX_IMM, `OP_LDX_ZPY: begin
                dec.ld  = 1'b1;                        // X <= M
                dec.dst = `REG_X;
                dec.src = `SRC_M;
                dec.alu = ALU_PASS;
            end
            `OP_LDY_IMM: begin
                dec.ld  = 1'b1;                        // Y <= M
                dec.dst = `REG_Y;
                dec.src = `SRC_M;
                dec.alu = ALU_PASS;
            end
            `OP_INX, `OP_DEX: begin
                dec.ld  = 1'b1;                        // X <= X +/- 1
                dec.dst = `REG_X;
                dec.src = `SRC_X;
                dec.alu = (db == `OP_INX) ? ALU_INC : ALU_DEC;
            end
            default: ;
        endcase
        dec.add_x = db inside {`OP_LDA_ZPX, `OP_LDA_ABSX, `OP_LDA_INDX, `OP_JMP_INDX};
        dec.add_y = db inside {`OP_LDA_INDY, `OP_LDX_ZPY, `OP_LDA_ABSY};
        dec.jmp   = db inside {`OP_JMP_ABS, `OP_JMP_IND, `OP_JMP_INDX};
        dec.ind   = db inside {`OP_JMP_IND, `OP_JMP_INDX};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;
        end else if (rdy) begin
            if (sync) begin
                instr <= dec;                          // Capture on leaving SYNC
            end else if (state == ctl65_pkg::ABS1) begin
                instr.ind   <= 1'b0;                   // Indirect pass taken once
                instr.add_x <= 1'b0;                   // X added to pointer only
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_sequencer.sv ====
// State register of the sequencer. Walks the states of the current
// addressing mode and flags the opcode fetch cycle on sync.
`timescale 1ns/1ns
`default_nettype none

module cpu_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rdy,
    input  ctl65_pkg::state_t  entry,
    input  ctl65_pkg::instr_t  instr,
    output ctl65_pkg::state_t  state,
    output logic               sync
);

    ctl65_pkg::state_t state_nxt;

    always_comb begin
        case (state)
            ctl65_pkg::INIT: state_nxt = ctl65_pkg::SYNC;
            ctl65_pkg::SYNC: state_nxt = entry;        // From decode
            ctl65_pkg::IMM0: state_nxt = ctl65_pkg::SYNC;
            ctl65_pkg::COND: state_nxt = ctl65_pkg::SYNC;
            ctl65_pkg::ZERO: state_nxt = ctl65_pkg::BACK;
            ctl65_pkg::ABS0: state_nxt = ctl65_pkg::ABS1;
            ctl65_pkg::ABS1: begin
                if (instr.ind)
                    state_nxt = ctl65_pkg::ABS0;       // Fetch the pointed address
                else if (instr.jmp)
                    state_nxt = ctl65_pkg::SYNC;       // Jump target on AB
                else
                    state_nxt = ctl65_pkg::BACK;
            end
            ctl65_pkg::IND0: state_nxt = ctl65_pkg::IND1;
            ctl65_pkg::IND1: state_nxt = ctl65_pkg::IND2;
            ctl65_pkg::IND2: state_nxt = ctl65_pkg::BACK;
            ctl65_pkg::BACK: state_nxt = ctl65_pkg::SYNC;
            default:         state_nxt = ctl65_pkg::SYNC;
        endcase
    end

    // Held while rdy is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= ctl65_pkg::INIT;
        else if (rdy)
            state <= state_nxt;
    end

    assign sync = (state == ctl65_pkg::SYNC);

endmodule

`default_nettype wire

// ==== verilog/address_control.sv ====
// Address path control. Each state selects one of the AB modes and the
// mode expands into the iph_abh, abl_sel, abl_src and abl_ci controls.
`timescale 1ns/1ns
`default_nettype none
`include "ctl65_settings.svh"

module address_control (
    input  ctl65_pkg::state_t        state,
    input  logic                     cond,
    input  logic [`CTL65_DATA_W-1:0] db,
    output ctl65_pkg::ab_op_t        ab_op
);

    ctl65_pkg::ab_mode_t mode;
    logic                back;

    assign back = cond & db[`CTL65_DATA_W-1];          // Taken, negative offset

    always_comb begin
        case (state)
            ctl65_pkg::INIT: mode = ctl65_pkg::AB_KEEP;
            ctl65_pkg::SYNC: mode = ctl65_pkg::AB_INC_PC;
            ctl65_pkg::IMM0: mode = ctl65_pkg::AB_INC_PC;
            ctl65_pkg::ABS0: mode = ctl65_pkg::AB_INC_PC;
            ctl65_pkg::ABS1: mode = ctl65_pkg::AB_ABS_PC;
            ctl65_pkg::IND0: mode = ctl65_pkg::AB_ZP_PC;
            ctl65_pkg::ZERO: mode = ctl65_pkg::AB_ZP_PC;
            ctl65_pkg::IND1: mode = ctl65_pkg::AB_INC;     // Pointer high byte
            ctl65_pkg::IND2: mode = ctl65_pkg::AB_ABS;
            ctl65_pkg::BACK: mode = ctl65_pkg::AB_PC;      // Return to program
            ctl65_pkg::COND: mode = ctl65_pkg::AB_BRANCH;
            default:         mode = ctl65_pkg::AB_KEEP;
        endcase
    end

    always_comb begin
        ab_op.abl_sel = mode[1:0];                     // ABL mux select
        ab_op.abl_ci  = mode[2];                       // ABL carry in
        case (mode)
            ctl65_pkg::AB_PC: begin
                ab_op.iph_abh = 7'b000_1010;
                ab_op.abl_src = 2'b10;
            end
            ctl65_pkg::AB_ABS_PC: begin
                ab_op.iph_abh = 7'b111_1110;           // Store PC
                ab_op.abl_src = 2'b01;
            end
            ctl65_pkg::AB_ZP_PC: begin
                ab_op.iph_abh = 7'b111_0000;           // ABH forced to 00
                ab_op.abl_src = 2'b01;
            end
            ctl65_pkg::AB_INC_PC: begin
                ab_op.iph_abh = 7'b011_0110;
                ab_op.abl_src = 2'b11;
            end
            ctl65_pkg::AB_BRANCH: begin
                // FF high offset when going back, 00 otherwise
                ab_op.iph_abh = back ? 7'b011_0111 : 7'b011_0110;
                ab_op.abl_src = 2'b11;
            end
            ctl65_pkg::AB_ABS: begin
                ab_op.iph_abh = 7'b001_1110;           // Keep PC
                ab_op.abl_src = 2'b01;
            end
            default: begin
                ab_op.iph_abh = 7'b001_0110;           // Keep and increment
                ab_op.abl_src = 2'b11;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/datapath_control.sv ====
// Register file and ALU control words, decoded per state from the fields
// that opcode_decode holds for the running instruction.
`timescale 1ns/1ns
`default_nettype none
`include "ctl65_settings.svh"

module datapath_control (
    input  ctl65_pkg::state_t  state,
    input  ctl65_pkg::instr_t  instr,
    output ctl65_pkg::reg_op_t reg_op,
    output ctl65_pkg::alu_op_t alu_op
);

    localparam logic [8:0] ALU_LDM  = 9'b1_0_00_000_00;    // Load M
    localparam logic [8:0] ALU_IDLE = 9'b0_0_00_000_00;

    // Index register read for address calculation
    always_comb begin
        reg_op = {1'b0, `REG_X, `SRC_Z};               // Zero offset, no write
        case (state)
            ctl65_pkg::IND0: begin
                if (instr.add_x)
                    reg_op.src = `SRC_X;               // (ZP,X)
            end
            ctl65_pkg::IND2: begin
                if (instr.add_y)
                    reg_op.src = `SRC_Y;               // (ZP),Y
            end
            ctl65_pkg::ZERO, ctl65_pkg::ABS1: begin
                if (instr.add_x)
                    reg_op.src = `SRC_X;
                else if (instr.add_y)
                    reg_op.src = `SRC_Y;
            end
            ctl65_pkg::SYNC:
                reg_op = {instr.ld, instr.dst, instr.src};  // Write-back of last op
            default: ;
        endcase
    end

    always_comb begin
        case (state)
            ctl65_pkg::IMM0: alu_op = ALU_LDM;
            ctl65_pkg::BACK: alu_op = ALU_LDM;
            ctl65_pkg::SYNC: alu_op = {2'b00, instr.alu};
            default:         alu_op = ALU_IDLE;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ctl65_top.sv ====
// Top of the ctl65 control unit. Connects decode, sequencer, address control
// and datapath control; all output words follow the registered state.
`timescale 1ns/1ns
`default_nettype none
`include "ctl65_settings.svh"

module ctl65_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rdy,               // Stall when low
    input  logic                     cond,              // Branch taken
    input  logic [`CTL65_DATA_W-1:0] db,
    output logic                     sync,              // Opcode fetch
    output ctl65_pkg::ab_op_t        ab_op,
    output ctl65_pkg::reg_op_t       reg_op,
    output ctl65_pkg::alu_op_t       alu_op
);

    ctl65_pkg::instr_t instr;                          // Held fields
    ctl65_pkg::state_t entry;                          // State after SYNC
    ctl65_pkg::state_t state;

    opcode_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .rdy   (rdy),
        .sync  (sync),
        .state (state),
        .db    (db),
        .instr (instr),
        .entry (entry)
    );

    cpu_sequencer u_seq (
        .clk   (clk),
        .rst_n (rst_n),
        .rdy   (rdy),
        .entry (entry),
        .instr (instr),
        .state (state),
        .sync  (sync)
    );

    address_control u_addr (
        .state (state),
        .cond  (cond),
        .db    (db),
        .ab_op (ab_op)
    );

    datapath_control u_dp (
        .state  (state),
        .instr  (instr),
        .reg_op (reg_op),
        .alu_op (alu_op)
    );

endmodule

`default_nettype wire

// ==== tests/tb_ctl65.sv ====
// Testbench for ctl65_top. Plays program memory on db, stalls with rdy at
// random and checks the control words with concurrent assertions against a
// small reference model of the instruction timing.
`timescale 1ns/1ns
`default_nettype none
`include "ctl65_settings.svh"

module tb_ctl65;

    localparam int          CLK_PERIOD    = 4;
    localparam int          CYCLES_PER_OP = 200;               // Watchdog budget
    localparam int          N_KNOWN       = 18;
    localparam logic [11:0] AB_KEEP_WORD  = {7'b001_0110, 2'b00, 2'b11, 1'b0};
    localparam logic [6:0]  IPH_FWD       = 7'b011_0110;       // Offset high 00
    localparam logic [6:0]  IPH_BACK      = 7'b011_0111;       // Offset high FF
    localparam logic [6:0]  ALU_PASS      = 7'b00_011_00;
    localparam logic [6:0]  ALU_INC       = 7'b00_100_01;
    localparam logic [6:0]  ALU_DEC       = 7'b00_101_00;

    logic                     clk;
    logic                     rst_n;
    logic                     rdy;
    logic                     cond;
    logic [`CTL65_DATA_W-1:0] db;
    logic                     sync;
    ctl65_pkg::ab_op_t        ab_op;
    ctl65_pkg::reg_op_t       reg_op;
    ctl65_pkg::alu_op_t       alu_op;

    logic [7:0]               last_op;                         // Opcode of last fetch
    logic                     have_op;
    int                       cnt;                             // Enabled cycles since sync
    logic [1:0]               edge_cnt;                        // Edges since reset release
    logic                     stalled;                         // rdy low at last edge
    logic                     prev_sync;
    ctl65_pkg::ab_op_t        prev_ab;
    ctl65_pkg::reg_op_t       prev_reg;
    ctl65_pkg::alu_op_t       prev_alu;

    logic [7:0]               ops [$];                         // Program opcodes in order
    int                       idx;
    int                       pass;
    int                       i;
    int                       k;
    integer                   seed;
    logic [31:0]              rnd;
    logic                     done;
    logic                     ops_ready;

    ctl65_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .rdy    (rdy),
        .cond   (cond),
        .db     (db),
        .sync   (sync),
        .ab_op  (ab_op),
        .reg_op (reg_op),
        .alu_op (alu_op)
    );

    function automatic logic [7:0] nth_known(input int n);
        case (n)
            0:  return `OP_LDA_IMM;
            1:  return `OP_LDA_ZP;
            2:  return `OP_LDA_ZPX;
            3:  return `OP_LDA_ABS;
            4:  return `OP_LDA_ABSX;
            5:  return `OP_LDA_ABSY;
            6:  return `OP_LDA_INDX;
            7:  return `OP_LDA_INDZ;
            8:  return `OP_LDA_INDY;
            9:  return `OP_LDX_IMM;
            10: return `OP_LDX_ZPY;
            11: return `OP_LDY_IMM;
            12: return `OP_INX;
            13: return `OP_DEX;
            14: return `OP_BRA;
            15: return `OP_JMP_ABS;
            16: return `OP_JMP_IND;
            default: return `OP_JMP_INDX;
        endcase
    endfunction

    function automatic logic is_decoded(input logic [7:0] op);
        logic found;
        found = 1'b0;
        for (int n = 0; n < N_KNOWN; n++)
            if (nth_known(n) == op)
                found = 1'b1;
        return found;
    endfunction

    // Enabled cycles from one sync to the next
    function automatic int cycles_for(input logic [7:0] op);
        case (op)
            `OP_LDA_IMM, `OP_LDX_IMM, `OP_LDY_IMM, `OP_BRA:         return 2;
            `OP_LDA_ZP, `OP_LDA_ZPX, `OP_LDX_ZPY, `OP_JMP_ABS:      return 3;
            `OP_LDA_ABS, `OP_LDA_ABSX, `OP_LDA_ABSY:                return 4;
            `OP_LDA_INDX, `OP_LDA_INDZ, `OP_LDA_INDY,
            `OP_JMP_IND, `OP_JMP_INDX:                              return 5;
            default:                                                return 1;
        endcase
    endfunction

    function automatic logic writes_reg(input logic [7:0] op);
        return op inside {`OP_LDA_IMM, `OP_LDA_ZP, `OP_LDA_ZPX, `OP_LDA_ABS, `OP_LDA_ABSX,
                          `OP_LDA_ABSY, `OP_LDA_INDX, `OP_LDA_INDZ, `OP_LDA_INDY,
                          `OP_LDX_IMM, `OP_LDX_ZPY, `OP_LDY_IMM, `OP_INX, `OP_DEX};
    endfunction

    // Write-back word seen at the following sync
    function automatic logic [6:0] reg_word_for(input logic [7:0] op);
        case (op)
            `OP_LDX_IMM, `OP_LDX_ZPY: return {1'b1, `REG_X, `SRC_M};
            `OP_LDY_IMM:              return {1'b1, `REG_Y, `SRC_M};
            `OP_INX, `OP_DEX:         return {1'b1, `REG_X, `SRC_X};
            default:                  return {1'b1, `REG_A, `SRC_M};    // LDA
        endcase
    endfunction

    function automatic logic [8:0] alu_word_for(input logic [7:0] op);
        case (op)
            `OP_INX: return {2'b00, ALU_INC};
            `OP_DEX: return {2'b00, ALU_DEC};
            default: return {2'b00, ALU_PASS};
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "Stopped at the first failed check");
    endtask

    // Reference timing model updated on every edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_op   <= 8'h00;
            have_op   <= 1'b0;
            cnt       <= 0;
            edge_cnt  <= 2'd0;
            stalled   <= 1'b0;
            prev_sync <= 1'b0;
            prev_ab   <= '0;
            prev_reg  <= '0;
            prev_alu  <= '0;
        end else begin
            if (edge_cnt != 2'd2)
                edge_cnt <= edge_cnt + 2'd1;
            stalled   <= !rdy;
            prev_sync <= sync;                                  // Words of this cycle
            prev_ab   <= ab_op;
            prev_reg  <= reg_op;
            prev_alu  <= alu_op;
            if (rdy) begin
                if (sync) begin
                    last_op <= db;                              // Opcode taken
                    have_op <= 1'b1;
                    cnt     <= 1;
                end else begin
                    cnt <= cnt + 1;
                end
            end
        end
    end

    a_init_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (edge_cnt == 2'd0) |-> (!sync && ab_op == AB_KEEP_WORD))
        else report_error("first cycle after reset is not INIT with the keep word");

    a_first_sync: assert property (@(posedge clk) disable iff (!rst_n)
        (edge_cnt == 2'd1) |-> sync)
        else report_error("no sync in the second cycle after reset");

    a_cycle_count: assert property (@(posedge clk) disable iff (!rst_n)
        (have_op && sync) |-> (cnt == cycles_for(last_op)))
        else report_error($sformatf("opcode %02h took %0d cycles", last_op, cnt));

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stalled |-> (sync == prev_sync && ab_op == prev_ab &&
                     reg_op == prev_reg && alu_op == prev_alu))
        else report_error("outputs changed during a stall");

    a_write_back: assert property (@(posedge clk) disable iff (!rst_n)
        (have_op && sync && writes_reg(last_op)) |->
            (reg_op == reg_word_for(last_op) && alu_op == alu_word_for(last_op)))
        else report_error($sformatf("write-back words wrong after opcode %02h", last_op));

    a_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (sync && !(have_op && writes_reg(last_op))) |-> !reg_op.write)
        else report_error($sformatf("register write after opcode %02h", last_op));

    a_branch_dir: assert property (@(posedge clk) disable iff (!rst_n)
        (have_op && !sync && last_op == `OP_BRA) |->
            (ab_op.iph_abh == ((cond && db[7]) ? IPH_BACK : IPH_FWD)))
        else report_error("branch direction pattern wrong in COND");

    a_abs_index: assert property (@(posedge clk) disable iff (!rst_n)
        (have_op && !sync && cnt == 2 &&
         (last_op == `OP_LDA_ABSX || last_op == `OP_LDA_ABSY)) |->
            (reg_op.src == ((last_op == `OP_LDA_ABSX) ? `SRC_X : `SRC_Y)))
        else report_error("index source wrong in ABS1");

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (ops_ready);
        #(ops.size() * CYCLES_PER_OP * CLK_PERIOD);
        $display("Timeout: the program did not run to its end in time");
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst_n     = 1'b0;
        rdy       = 1'b1;                                       // High through INIT
        cond      = 1'b0;
        db        = '0;
        done      = 1'b0;
        ops_ready = 1'b0;
        idx       = 0;
        seed      = 32'h0233_6635;
        // Four rotated passes over the decoded set with three unknown bytes each
        for (pass = 0; pass < 4; pass++) begin
            for (i = 0; i < N_KNOWN; i++)
                ops.push_back(nth_known((i + pass * 5) % N_KNOWN));
            k = 0;
            while (k < 3) begin
                rnd = $random(seed);
                if (!is_decoded(rnd[7:0])) begin
                    ops.push_back(rnd[7:0]);
                    k++;
                end
            end
        end
        ops_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!done) begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            if (rdy) begin                                      // Bus held after a stall
                cond = rnd[8];
                if (!sync) begin
                    db = rnd[7:0];                              // Operand byte
                end else if (idx < ops.size()) begin
                    db = ops[idx];
                    idx++;
                end else begin
                    db   = 8'hEA;                               // Closes the last opcode
                    done = 1'b1;
                end
            end
            rdy = (rnd[18:16] != 3'd0);                         // Low about 1 in 8
        end
        repeat (3) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ctl65.f ====
+incdir+verilog
verilog/ctl65_pkg.sv
verilog/opcode_decode.sv
verilog/cpu_sequencer.sv
verilog/address_control.sv
verilog/datapath_control.sv
verilog/ctl65_top.sv
tests/tb_ctl65.sv

// ==== run_ctl65.sh ====
#!/usr/bin/env bash
# Build the ctl65 testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f ctl65.f --top-module tb_ctl65 -Mdir obj_dir

./obj_dir/Vtb_ctl65 | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "ctl65 simulation passed"
    exit 0
else
    echo "ctl65 simulation failed, see sim.log"
    exit 1
fi
